// ==== hw/pcie_regs_params.svh ====
`ifndef PCIE_REGS_PARAMS_SVH
`define PCIE_REGS_PARAMS_SVH

// register file size, as address bits
`define PCIE_REGS_REG_ADDR_BITS 4

// read requests waiting for a completion slot
`define PCIE_REGS_CPL_DEPTH 4

// fmt/type byte, DW0 bits 31:24
`define PCIE_REGS_FMT_MWR32 8'h40
`define PCIE_REGS_FMT_MRD32 8'h00
`define PCIE_REGS_FMT_CPLD 8'h4A

`endif

// ==== hw/pcie_regs_pkg.sv ====
`default_nettype none

`include "pcie_regs_params.svh"

package pcie_regs_pkg;

   typedef logic [31:0] dword_t;
   typedef logic [63:0] qword_t;

   // bus[15:8], device[7:3], function[2:0]
   typedef logic [15:0] req_id_t;
   typedef logic [7:0] tag_t;
   typedef logic [`PCIE_REGS_REG_ADDR_BITS-1:0] reg_index_t;
   typedef logic [6:0] lower_addr_t;

   typedef enum logic [1:0]
   {
      RX_HDR,
      RX_ADDR,
      RX_SKIP
   } rx_state_t;

   typedef enum logic [1:0]
   {
      CPL_IDLE,
      CPL_HDR,
      CPL_DATA
   } cpl_state_t;

endpackage

`default_nettype wire

// ==== hw/tlp_rx_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pcie_regs_params.svh"

module tlp_rx_decode
(
   input  wire logic                        clock,
   input  wire logic                        rst_n,
   input  wire logic                        flush,
   input  wire pcie_regs_pkg::qword_t       rx_tdata,
   input  wire logic                        rx_tvalid,
   input  wire logic                        rx_tlast,
   output logic                             wr_en,
   output pcie_regs_pkg::reg_index_t        wr_index,
   output pcie_regs_pkg::dword_t            wr_data,
   output logic                             rd_en,
   output pcie_regs_pkg::reg_index_t        rd_index,
   output pcie_regs_pkg::req_id_t           rd_req_id,
   output pcie_regs_pkg::tag_t              rd_tag,
   output pcie_regs_pkg::lower_addr_t       rd_lower_addr
);

   pcie_regs_pkg::rx_state_t   state;
   pcie_regs_pkg::reg_index_t  index_q;
   logic                       is_write;
   logic [7:0]                 fmt_type;
   logic [9:0]                 length;
   logic                       hdr_ok;

   // header fields of beat 0, DW0
   assign fmt_type = rx_tdata[31:24];
   assign length = rx_tdata[9:0];
   assign hdr_ok = (fmt_type == `PCIE_REGS_FMT_MWR32 || fmt_type == `PCIE_REGS_FMT_MRD32)
                   && length == 10'd1;

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= pcie_regs_pkg::RX_HDR;
         is_write <= 1'b0;
         wr_en <= 1'b0;
         rd_en <= 1'b0;
      end
      else
      begin
         wr_en <= 1'b0;
         rd_en <= 1'b0;
         if (flush)
            state <= pcie_regs_pkg::RX_HDR;
         else if (rx_tvalid)
         begin
            case (state)
               pcie_regs_pkg::RX_HDR:
               begin
                  is_write <= fmt_type == `PCIE_REGS_FMT_MWR32;
                  // a single-beat TLP can never be a 3DW request
                  if (rx_tlast)
                     state <= pcie_regs_pkg::RX_HDR;
                  else if (hdr_ok)
                     state <= pcie_regs_pkg::RX_ADDR;
                  else
                     state <= pcie_regs_pkg::RX_SKIP;
               end
               pcie_regs_pkg::RX_ADDR:
               begin
                  if (rx_tlast)
                  begin
                     wr_en <= is_write;
                     rd_en <= !is_write;
                     state <= pcie_regs_pkg::RX_HDR;
                  end
                  else
                     state <= pcie_regs_pkg::RX_SKIP;
               end
               pcie_regs_pkg::RX_SKIP:
               begin
                  if (rx_tlast)
                     state <= pcie_regs_pkg::RX_HDR;
               end
               default:
                  state <= pcie_regs_pkg::RX_HDR;
            endcase
         end
      end
   end

   // request fields, held until the strobe
   always_ff @(posedge clock)
   begin
      if (rx_tvalid && state == pcie_regs_pkg::RX_HDR)
      begin
         rd_req_id <= rx_tdata[63:48];
         rd_tag <= rx_tdata[47:40];
      end
      if (rx_tvalid && state == pcie_regs_pkg::RX_ADDR)
      begin
         // dword address in DW2, data in DW3
         index_q <= rx_tdata[`PCIE_REGS_REG_ADDR_BITS+1:2];
         rd_lower_addr <= rx_tdata[6:0];
         wr_data <= rx_tdata[63:32];
      end
   end

   assign wr_index = index_q;
   assign rd_index = index_q;

endmodule

`default_nettype wire

// ==== hw/reg_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pcie_regs_params.svh"

module reg_bank
(
   input  wire logic                         clock,
   input  wire logic                         rst_n,
   input  wire logic                         wr_en,
   input  wire pcie_regs_pkg::reg_index_t    wr_index,
   input  wire pcie_regs_pkg::dword_t        wr_data,
   input  wire logic                         rd_en,
   input  wire pcie_regs_pkg::reg_index_t    rd_index,
   input  wire pcie_regs_pkg::req_id_t       rd_req_id,
   input  wire pcie_regs_pkg::tag_t          rd_tag,
   input  wire pcie_regs_pkg::lower_addr_t   rd_lower_addr,
   output logic                              rd_valid,
   output pcie_regs_pkg::dword_t             rd_data,
   output pcie_regs_pkg::req_id_t            cpl_req_id,
   output pcie_regs_pkg::tag_t               cpl_tag,
   output pcie_regs_pkg::lower_addr_t        cpl_lower_addr
);

   localparam int NUM_REGS = 1 << `PCIE_REGS_REG_ADDR_BITS;

   pcie_regs_pkg::dword_t regs [NUM_REGS];

   // device registers, cleared only by rst_n
   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
      end
      else if (wr_en)
         regs[wr_index] <= wr_data;
   end

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
         rd_valid <= 1'b0;
      else
         rd_valid <= rd_en;
   end

   // same-cycle write to the read index returns the old value
   always_ff @(posedge clock)
   begin
      if (rd_en)
      begin
         rd_data <= regs[rd_index];
         cpl_req_id <= rd_req_id;
         cpl_tag <= rd_tag;
         cpl_lower_addr <= rd_lower_addr;
      end
   end

endmodule

`default_nettype wire

// ==== hw/cpl_tlp_build.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pcie_regs_params.svh"

module cpl_tlp_build
(
   input  wire logic                         clock,
   input  wire logic                         rst_n,
   input  wire logic                         flush,
   input  wire logic                         rd_valid,
   input  wire pcie_regs_pkg::dword_t        rd_data,
   input  wire pcie_regs_pkg::req_id_t       cpl_req_id,
   input  wire pcie_regs_pkg::tag_t          cpl_tag,
   input  wire pcie_regs_pkg::lower_addr_t   cpl_lower_addr,
   input  wire pcie_regs_pkg::req_id_t       completer_id,
   input  wire logic                         tx_tready,
   output pcie_regs_pkg::qword_t             tx_tdata,
   output logic                              tx_tvalid,
   output logic                              tx_tlast,
   output logic                              cpl_pending
);

   localparam int DEPTH = `PCIE_REGS_CPL_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   pcie_regs_pkg::dword_t       q_data [DEPTH];
   pcie_regs_pkg::req_id_t      q_req_id [DEPTH];
   pcie_regs_pkg::tag_t         q_tag [DEPTH];
   pcie_regs_pkg::lower_addr_t  q_lower [DEPTH];

   pcie_regs_pkg::cpl_state_t   state;
   logic [PTR_W-1:0]            wr_ptr;
   logic [PTR_W-1:0]            rd_ptr;
   logic [PTR_W:0]              count;
   logic                        push;
   logic                        pop;

   // a read arriving with the queue full is lost
   assign push = rd_valid && count != DEPTH[PTR_W:0] && !flush;
   assign pop = state == pcie_regs_pkg::CPL_DATA && tx_tready;

   always_ff @(posedge clock)
   begin
      if (push)
      begin
         q_data[wr_ptr] <= rd_data;
         q_req_id[wr_ptr] <= cpl_req_id;
         q_tag[wr_ptr] <= cpl_tag;
         q_lower[wr_ptr] <= cpl_lower_addr;
      end
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= pcie_regs_pkg::CPL_IDLE;
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else if (flush)
      begin
         state <= pcie_regs_pkg::CPL_IDLE;
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;

         case (state)
            pcie_regs_pkg::CPL_IDLE:
               if (count != '0)
                  state <= pcie_regs_pkg::CPL_HDR;
            pcie_regs_pkg::CPL_HDR:
               if (tx_tready)
                  state <= pcie_regs_pkg::CPL_DATA;
            pcie_regs_pkg::CPL_DATA:
            begin
               // go straight on to the next completion if one waits
               if (tx_tready)
               begin
                  if (count > 1 || push)
                     state <= pcie_regs_pkg::CPL_HDR;
                  else
                     state <= pcie_regs_pkg::CPL_IDLE;
               end
            end
            default:
               state <= pcie_regs_pkg::CPL_IDLE;
         endcase
      end
   end

   // head entry stays put until its data beat is taken
   always_comb
   begin
      if (state == pcie_regs_pkg::CPL_DATA)
         tx_tdata = {q_data[rd_ptr], q_req_id[rd_ptr], q_tag[rd_ptr], 1'b0, q_lower[rd_ptr]};
      else
         tx_tdata = {completer_id, 3'b000, 1'b0, 12'd4, `PCIE_REGS_FMT_CPLD, 14'd0, 10'd1};
   end

   assign tx_tvalid = state != pcie_regs_pkg::CPL_IDLE;
   assign tx_tlast = state == pcie_regs_pkg::CPL_DATA;
   assign cpl_pending = count != '0;

endmodule

`default_nettype wire

// ==== hw/core_side_glue.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_side_glue
(
   input  wire logic                     clock,
   input  wire logic                     rst_n,
   input  wire logic                     user_reset,
   input  wire logic                     user_lnk_up,
   input  wire logic [7:0]               cfg_bus_number,
   input  wire logic [4:0]               cfg_device_number,
   input  wire logic [2:0]               cfg_function_number,
   input  wire logic                     cfg_to_turnoff,
   input  wire logic                     cpl_pending,
   input  wire logic                     interrupt,
   input  wire logic                     cfg_interrupt_rdy,
   output logic                          pcie_reset,
   output pcie_regs_pkg::req_id_t        pcie_id,
   output logic                          cfg_turnoff_ok,
   output logic                          cfg_interrupt
);

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pcie_reset <= 1'b1;
         pcie_id <= '0;
         cfg_turnoff_ok <= 1'b0;
         cfg_interrupt <= 1'b0;
      end
      else
      begin
         // link down counts as reset for the datapath
         pcie_reset <= user_reset | ~user_lnk_up;
         pcie_id <= {cfg_bus_number, cfg_device_number, cfg_function_number};

         // no ack while a completion still has to go out
         cfg_turnoff_ok <= cfg_to_turnoff & ~cpl_pending;

         // request held until the core takes it
         if (interrupt)
            cfg_interrupt <= 1'b1;
         else if (cfg_interrupt_rdy)
            cfg_interrupt <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== hw/pcie_regs_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcie_regs_top
(
   input  wire logic                     clock,
   input  wire logic                     rst_n,
   input  wire pcie_regs_pkg::qword_t    rx_tdata,
   input  wire logic                     rx_tvalid,
   input  wire logic                     rx_tlast,
   output pcie_regs_pkg::qword_t         tx_tdata,
   output logic                          tx_tvalid,
   output logic                          tx_tlast,
   input  wire logic                     tx_tready,
   input  wire logic                     user_reset,
   input  wire logic                     user_lnk_up,
   input  wire logic [7:0]               cfg_bus_number,
   input  wire logic [4:0]               cfg_device_number,
   input  wire logic [2:0]               cfg_function_number,
   input  wire logic                     cfg_to_turnoff,
   output logic                          cfg_turnoff_ok,
   output logic                          cfg_interrupt,
   input  wire logic                     cfg_interrupt_rdy,
   output logic                          pcie_reset,
   output pcie_regs_pkg::req_id_t        pcie_id,
   input  wire logic                     interrupt
);

   logic                         wr_en;
   pcie_regs_pkg::reg_index_t    wr_index;
   pcie_regs_pkg::dword_t        wr_data;
   logic                         rd_en;
   pcie_regs_pkg::reg_index_t    rd_index;
   pcie_regs_pkg::req_id_t       rd_req_id;
   pcie_regs_pkg::tag_t          rd_tag;
   pcie_regs_pkg::lower_addr_t   rd_lower_addr;
   logic                         rd_valid;
   pcie_regs_pkg::dword_t        rd_data;
   pcie_regs_pkg::req_id_t       cpl_req_id;
   pcie_regs_pkg::tag_t          cpl_tag;
   pcie_regs_pkg::lower_addr_t   cpl_lower_addr;
   logic                         cpl_pending;

   tlp_rx_decode rx_decode_i
   (
      .clock(clock),
      .rst_n(rst_n),
      .flush(pcie_reset),
      .rx_tdata(rx_tdata),
      .rx_tvalid(rx_tvalid),
      .rx_tlast(rx_tlast),
      .wr_en(wr_en),
      .wr_index(wr_index),
      .wr_data(wr_data),
      .rd_en(rd_en),
      .rd_index(rd_index),
      .rd_req_id(rd_req_id),
      .rd_tag(rd_tag),
      .rd_lower_addr(rd_lower_addr)
   );

   reg_bank reg_bank_i
   (
      .clock(clock),
      .rst_n(rst_n),
      .wr_en(wr_en),
      .wr_index(wr_index),
      .wr_data(wr_data),
      .rd_en(rd_en),
      .rd_index(rd_index),
      .rd_req_id(rd_req_id),
      .rd_tag(rd_tag),
      .rd_lower_addr(rd_lower_addr),
      .rd_valid(rd_valid),
      .rd_data(rd_data),
      .cpl_req_id(cpl_req_id),
      .cpl_tag(cpl_tag),
      .cpl_lower_addr(cpl_lower_addr)
   );

   cpl_tlp_build cpl_build_i
   (
      .clock(clock),
      .rst_n(rst_n),
      .flush(pcie_reset),
      .rd_valid(rd_valid),
      .rd_data(rd_data),
      .cpl_req_id(cpl_req_id),
      .cpl_tag(cpl_tag),
      .cpl_lower_addr(cpl_lower_addr),
      .completer_id(pcie_id),
      .tx_tready(tx_tready),
      .tx_tdata(tx_tdata),
      .tx_tvalid(tx_tvalid),
      .tx_tlast(tx_tlast),
      .cpl_pending(cpl_pending)
   );

   core_side_glue glue_i
   (
      .clock(clock),
      .rst_n(rst_n),
      .user_reset(user_reset),
      .user_lnk_up(user_lnk_up),
      .cfg_bus_number(cfg_bus_number),
      .cfg_device_number(cfg_device_number),
      .cfg_function_number(cfg_function_number),
      .cfg_to_turnoff(cfg_to_turnoff),
      .cpl_pending(cpl_pending),
      .interrupt(interrupt),
      .cfg_interrupt_rdy(cfg_interrupt_rdy),
      .pcie_reset(pcie_reset),
      .pcie_id(pcie_id),
      .cfg_turnoff_ok(cfg_turnoff_ok),
      .cfg_interrupt(cfg_interrupt)
   );

endmodule

`default_nettype wire

// ==== bench/pcie_regs_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcie_regs_tb;

   localparam logic [15:0] COMPLETER_ID = {8'h3c, 5'h02, 3'h1};

   logic clock = 1'b0;
   logic rst_n;
   logic [63:0] rx_tdata;
   logic rx_tvalid;
   logic rx_tlast;
   logic [63:0] tx_tdata;
   logic tx_tvalid;
   logic tx_tlast;
   logic tx_tready;
   logic user_reset;
   logic user_lnk_up;
   logic cfg_to_turnoff;
   logic cfg_turnoff_ok;
   logic cfg_interrupt;
   logic cfg_interrupt_rdy;
   logic pcie_reset;
   logic [15:0] pcie_id;
   logic interrupt;

   integer seed;
   int ready_mode = 0;
   int num_tests = 0;
   int cur_id = 0;
   int errors = 0;
   int test_errors = 0;
   logic [31:0] mirror [16];

   // completions seen on the transmit stream
   logic [63:0] cpl_hdr_q [$];
   logic [63:0] cpl_data_q [$];
   logic [63:0] hdr_beat;
   logic have_hdr = 1'b0;
   logic held = 1'b0;
   logic [63:0] held_data;

   pcie_regs_top dut_i
   (
      .clock(clock),
      .rst_n(rst_n),
      .rx_tdata(rx_tdata),
      .rx_tvalid(rx_tvalid),
      .rx_tlast(rx_tlast),
      .tx_tdata(tx_tdata),
      .tx_tvalid(tx_tvalid),
      .tx_tlast(tx_tlast),
      .tx_tready(tx_tready),
      .user_reset(user_reset),
      .user_lnk_up(user_lnk_up),
      .cfg_bus_number(COMPLETER_ID[15:8]),
      .cfg_device_number(COMPLETER_ID[7:3]),
      .cfg_function_number(COMPLETER_ID[2:0]),
      .cfg_to_turnoff(cfg_to_turnoff),
      .cfg_turnoff_ok(cfg_turnoff_ok),
      .cfg_interrupt(cfg_interrupt),
      .cfg_interrupt_rdy(cfg_interrupt_rdy),
      .pcie_reset(pcie_reset),
      .pcie_id(pcie_id),
      .interrupt(interrupt)
   );

   always #5 clock = ~clock;

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("ERR test %0d %s got %h expected %h", cur_id, name, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic report_problem(input string msg);
      $display("test %0d: %s", cur_id, msg);
      errors++;
      test_errors++;
   endtask

   // 0 always ready, 1 random, 2 stalled
   always @(negedge clock)
   begin
      case (ready_mode)
         0: tx_tready <= 1'b1;
         1: tx_tready <= ($random(seed) & 3) != 0;
         default: tx_tready <= 1'b0;
      endcase
   end

   // core side of the transmit stream
   always @(posedge clock)
   begin
      if (held)
      begin
         compare_value("tx_tvalid", tx_tvalid, 64'd1);
         compare_value("tx_tdata", tx_tdata, held_data);
      end
      held = rst_n && tx_tvalid && !tx_tready;
      held_data = tx_tdata;
      if (rst_n && tx_tvalid && tx_tready)
      begin
         if (!tx_tlast)
         begin
            hdr_beat = tx_tdata;
            have_hdr = 1'b1;
         end
         else if (have_hdr)
         begin
            cpl_hdr_q.push_back(hdr_beat);
            cpl_data_q.push_back(tx_tdata);
            have_hdr = 1'b0;
         end
         else
            report_problem("completion data beat arrived without a header beat");
      end
   end

   function automatic logic [31:0] reg_addr(input logic [3:0] index);
      return 32'hf000_0040 | {26'd0, index, 2'b00};
   endfunction

   // 3DW request header with all first byte enables set
   function automatic logic [63:0] req_header(input logic [7:0] fmt, input logic [9:0] len,
                                              input logic [15:0] req_id, input logic [7:0] tag);
      return {req_id, tag, 8'h0f, fmt, 14'd0, len};
   endfunction

   task automatic set_ready_mode(input int mode);
      @(posedge clock);
      ready_mode = mode;
      @(negedge clock);
   endtask

   task automatic send_tlp(input logic [63:0] beat0, input logic [63:0] beat1);
      rx_tvalid = 1'b1;
      rx_tlast = 1'b0;
      rx_tdata = beat0;
      @(negedge clock);
      rx_tlast = 1'b1;
      rx_tdata = beat1;
      @(negedge clock);
      rx_tvalid = 1'b0;
      rx_tlast = 1'b0;
   endtask

   task automatic send_read(input logic [3:0] index, input logic [15:0] req_id,
                            input logic [7:0] tag);
      send_tlp(req_header(8'h00, 10'd1, req_id, tag), {32'd0, reg_addr(index)});
   endtask

   task automatic expect_cpl(input logic [3:0] index, input logic [15:0] req_id,
                             input logic [7:0] tag, input logic [31:0] data);
      logic [31:0] addr;
      int waited;
      addr = reg_addr(index);
      waited = 0;
      while (cpl_hdr_q.size() == 0 && waited < 100)
      begin
         @(negedge clock);
         waited++;
      end
      if (cpl_hdr_q.size() == 0)
         report_problem($sformatf("no completion arrived for tag %h", tag));
      else
      begin
         // CplD header of length 1 with success status and byte count 4
         compare_value("cpl beat 0", cpl_hdr_q.pop_front(),
                       {COMPLETER_ID, 16'h0004, 32'h4a00_0001});
         compare_value("cpl beat 1", cpl_data_q.pop_front(),
                       {data, req_id, tag, 1'b0, addr[6:0]});
      end
   endtask

   task automatic read_burst(input logic [3:0] first, input logic [15:0] req_id,
                             input logic [7:0] tag);
      logic [3:0] idx;
      logic [7:0] t;
      set_ready_mode(1);
      idx = first;
      t = tag;
      for (int i = 0; i < 4; i++)
      begin
         send_read(idx, req_id, t);
         idx++;
         t++;
      end
      idx = first;
      t = tag;
      for (int i = 0; i < 4; i++)
      begin
         expect_cpl(idx, req_id, t, mirror[idx]);
         idx++;
         t++;
      end
      set_ready_mode(0);
   endtask

   task automatic pulse_interrupt();
      compare_value("cfg_interrupt", cfg_interrupt, 64'd0);
      interrupt = 1'b1;
      @(negedge clock);
      interrupt = 1'b0;
      compare_value("cfg_interrupt", cfg_interrupt, 64'd1);
      repeat (3)
      begin
         @(negedge clock);
         compare_value("cfg_interrupt", cfg_interrupt, 64'd1);
      end
      cfg_interrupt_rdy = 1'b1;
      @(negedge clock);
      cfg_interrupt_rdy = 1'b0;
      compare_value("cfg_interrupt", cfg_interrupt, 64'd0);
   endtask

   task automatic turnoff_while_stalled(input logic [3:0] a, input logic [3:0] b,
                                        input logic [15:0] req_id, input logic [7:0] tag);
      int waited;
      set_ready_mode(2);
      send_read(a, req_id, tag);
      send_read(b, req_id, tag + 8'd1);
      repeat (4) @(negedge clock);
      cfg_to_turnoff = 1'b1;
      repeat (4)
      begin
         @(negedge clock);
         compare_value("cfg_turnoff_ok", cfg_turnoff_ok, 64'd0);
      end
      set_ready_mode(0);
      waited = 0;
      while (cpl_hdr_q.size() < 2 && waited < 100)
      begin
         compare_value("cfg_turnoff_ok", cfg_turnoff_ok, 64'd0);
         @(negedge clock);
         waited++;
      end
      // ack follows one clock after the last beat is taken
      compare_value("cfg_turnoff_ok", cfg_turnoff_ok, 64'd0);
      @(negedge clock);
      compare_value("cfg_turnoff_ok", cfg_turnoff_ok, 64'd1);
      cfg_to_turnoff = 1'b0;
      @(negedge clock);
      compare_value("cfg_turnoff_ok", cfg_turnoff_ok, 64'd0);
      expect_cpl(a, req_id, tag, mirror[a]);
      expect_cpl(b, req_id, tag + 8'd1, mirror[b]);
   endtask

   task automatic bounce_link(input logic [3:0] index);
      user_lnk_up = 1'b0;
      @(negedge clock);
      compare_value("pcie_reset", pcie_reset, 64'd1);
      repeat (3) @(negedge clock);
      user_lnk_up = 1'b1;
      @(negedge clock);
      compare_value("pcie_reset", pcie_reset, 64'd0);
      send_read(index, 16'h0100, 8'h80);
      expect_cpl(index, 16'h0100, 8'h80, mirror[index]);
   endtask

   initial
   begin
      wait (num_tests > 0);
      repeat (num_tests * 200) @(posedge clock);
      $display("watchdog expired after %0d cycles", num_tests * 200);
      $display("TB FAILED");
      $finish;
   end

   initial
   begin
      int fd;
      int rc;
      int failed;
      int id;
      logic [8*80-1:0] line;
      logic [63:0] op;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      int ids [$];
      logic [63:0] ops [$];
      logic [31:0] fa [$];
      logic [31:0] fb [$];
      logic [31:0] fc [$];
      logic [31:0] fd_q [$];

      rst_n = 1'b0;
      rx_tdata = '0;
      rx_tvalid = 1'b0;
      rx_tlast = 1'b0;
      tx_tready = 1'b1;
      user_reset = 1'b0;
      user_lnk_up = 1'b1;
      cfg_to_turnoff = 1'b0;
      cfg_interrupt_rdy = 1'b0;
      interrupt = 1'b0;
      seed = 32'hdc65_3b93;
      failed = 0;
      for (int i = 0; i < 16; i++)
         mirror[i] = '0;

      fd = $fopen("bench/pcie_regs_tests.txt", "r");
      if (fd == 0)
         report_problem("cannot open bench/pcie_regs_tests.txt");
      else
      begin
         while (!$feof(fd))
         begin
            rc = $fgets(line, fd);
            if (rc > 0 && $sscanf(line, "%d %s %h %h %h %h", id, op, f1, f2, f3, f4) == 6)
            begin
               ids.push_back(id);
               ops.push_back(op);
               fa.push_back(f1);
               fb.push_back(f2);
               fc.push_back(f3);
               fd_q.push_back(f4);
            end
         end
         $fclose(fd);
         num_tests = ids.size();
      end

      repeat (4) @(negedge clock);
      rst_n = 1'b1;
      compare_value("tx_tvalid", tx_tvalid, 64'd0);
      compare_value("cfg_interrupt", cfg_interrupt, 64'd0);
      compare_value("cfg_turnoff_ok", cfg_turnoff_ok, 64'd0);
      compare_value("pcie_reset", pcie_reset, 64'd1);
      repeat (2) @(negedge clock);
      compare_value("pcie_id", pcie_id, COMPLETER_ID);

      for (int i = 0; i < num_tests; i++)
      begin
         cur_id = ids[i];
         test_errors = 0;
         op = ops[i];
         if (op == "wr")
         begin
            send_tlp(req_header(8'h40, 10'd1, 16'h0100, 8'h01), {fb[i], reg_addr(fa[i][3:0])});
            repeat (3) @(negedge clock);
            mirror[fa[i][3:0]] = fb[i];
         end
         else if (op == "rd")
         begin
            send_read(fa[i][3:0], fb[i][15:0], fc[i][7:0]);
            expect_cpl(fa[i][3:0], fb[i][15:0], fc[i][7:0], fd_q[i]);
         end
         else if (op == "bad")
         begin
            send_tlp(req_header(fa[i][7:0], fb[i][9:0], 16'h0100, 8'hee),
                     {fd_q[i], reg_addr(fc[i][3:0])});
            repeat (8) @(negedge clock);
         end
         else if (op == "burst")
            read_burst(fa[i][3:0], fb[i][15:0], fc[i][7:0]);
         else if (op == "irq")
            pulse_interrupt();
         else if (op == "toff")
            turnoff_while_stalled(fa[i][3:0], fb[i][3:0], fc[i][15:0], fd_q[i][7:0]);
         else if (op == "link")
            bounce_link(fa[i][3:0]);
         else
            report_problem($sformatf("unknown opcode %0s", op));

         if (cpl_hdr_q.size() != 0)
            report_problem("unexpected completion on the transmit stream");
         cpl_hdr_q.delete();
         cpl_data_q.delete();
         if (test_errors == 0)
            $display("test %0d %0s ok", cur_id, op);
         else
         begin
            $display("test %0d %0s failed with %0d errors", cur_id, op, test_errors);
            failed++;
         end
      end

      $display("tests run %0d, tests failed %0d, errors %0d", num_tests, failed, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== pcie_regs.f ====
+incdir+hw
hw/pcie_regs_pkg.sv
hw/tlp_rx_decode.sv
hw/reg_bank.sv
hw/cpl_tlp_build.sv
hw/core_side_glue.sv
hw/pcie_regs_top.sv
bench/pcie_regs_tb.sv

// ==== Bender.yml ====
package:
  name: pcie_regs

sources:
  - include_dirs:
      - hw
    files:
      - hw/pcie_regs_pkg.sv
      - hw/tlp_rx_decode.sv
      - hw/reg_bank.sv
      - hw/cpl_tlp_build.sv
      - hw/core_side_glue.sv
      - hw/pcie_regs_top.sv
  - target: test
    files:
      - bench/pcie_regs_tb.sv

// ==== bench/pcie_regs_tests.txt ====
# id op f1 f2 f3 f4, fields in hex, unused fields zero
# wr: index data | rd: index req_id tag expected | bad: fmt/type length index data
# burst: first_index req_id tag | irq | toff: index_a index_b req_id tag | link: index
1 wr 3 cafef00d 0 0
2 rd 3 0100 11 cafef00d
3 wr a 12345678 0 0
4 wr 0 deadbeef 0 0
5 rd a 0208 22 12345678
6 bad 40 2 3 55555555
7 bad 60 1 a 66666666
8 bad 00 2 3 0
9 bad 44 1 0 77777777
10 rd 3 0100 33 cafef00d
11 rd 0 0100 34 deadbeef
12 wr f 0badf00d 0 0
13 burst e 0300 40 0
14 irq 0 0 0 0
15 toff 3 a 0400 50
16 link a 0 0 0
17 rd 5 0100 60 00000000
18 wr 5 a5a55a5a 0 0
19 burst 3 0500 70 0
20 link 5 0 0 0
21 rd a 0100 61 12345678
